// File: logic/phy_model_config.svh
`ifndef PHY_MODEL_CONFIG_SVH
`define PHY_MODEL_CONFIG_SVH

// ============================================================
// receive path widths
// ============================================================
`define NIBBLE_W        4
`define BYTE_W          8
`define LEN_W           16

// nibble that closes the preamble
`define SFD_NIBBLE      4'hd

// crc-32 in reflected register form, no final inversion
`define CRC_INIT        32'hffff_ffff
`define CRC_POLY        32'hedb8_8320
`define CRC_RESIDUE     32'hdebb_20e3

// ============================================================
// management interface
// ============================================================
`define MDIO_DATA_W     16
`define MDIO_ADDR_W     5

`define REG_BMCR        5'd0
`define REG_BMSR        5'd1
`define REG_CTRL1000    5'd9

`define BMSR_VALUE      16'hfe04
`define BMCR_RESET      16'h0000
`define CTRL1000_RESET  16'hffff

`endif

// File: logic/mii_pkg.sv
`include "phy_model_config.svh"

package mii_pkg;

    // data carried on the mii receive path
    typedef logic [`NIBBLE_W-1:0] nibble_t;
    typedef logic [`BYTE_W-1:0]   byte_t;

    // per-frame status
    typedef logic [`LEN_W-1:0]    frame_len_t;
    typedef logic [7:0]           frame_num_t;
    typedef logic [31:0]          crc_t;

    // deframer states
    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_PRE,
        RX_LO,
        RX_HI
    } rx_state_e;

endpackage

// File: logic/mdio_pkg.sv
`include "phy_model_config.svh"

package mdio_pkg;

    // register data and addresses on the management bus
    typedef logic [`MDIO_DATA_W-1:0] mdio_data_t;
    typedef logic [`MDIO_ADDR_W-1:0] mdio_addr_t;

    // counts up to 16 data bits
    typedef logic [4:0]              mdio_bit_cnt_t;

    // ============================================================
    // management frame states, one step per mdc rising edge
    // ============================================================
    typedef enum logic [3:0]
    {
        IDLE,
        START0,
        START1,
        OP_RD,
        OP_WR,
        PHYADDR,
        REGADDR,
        TURN0,
        TURN1,
        RDATA,
        WDATA,
        WXFR
    } mdio_state_e;

endpackage

// File: logic/mii_rx_deframer.sv
`timescale 1ns/1ps
`include "phy_model_config.svh"

module mii_rx_deframer
    import mii_pkg::*;
(
    input  logic    mtx_clk_i,
    input  logic    arst_n_i,
    input  nibble_t mrxd_i,
    input  logic    mrxdv_i,
    output logic    byte_valid_o,
    output byte_t   byte_data_o,
    output logic    frame_end_o,
    output logic    odd_nibble_o
);

    rx_state_e state_r;
    nibble_t   lo_nib_r;

    // ============================================================
    // framing state machine
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_r      <= RX_IDLE;
            byte_valid_o <= 1'b0;
            frame_end_o  <= 1'b0;
            odd_nibble_o <= 1'b0;
        end
        else
        begin
            byte_valid_o <= 1'b0;
            frame_end_o  <= 1'b0;
            odd_nibble_o <= 1'b0;

            case (state_r)
                RX_IDLE:
                    if (mrxdv_i)
                        state_r <= RX_PRE;
                // wait out the preamble for the sfd
                RX_PRE:
                    if (!mrxdv_i)
                        state_r <= RX_IDLE;
                    else if (mrxd_i == `SFD_NIBBLE)
                        state_r <= RX_LO;
                RX_LO:
                    if (mrxdv_i)
                        state_r <= RX_HI;
                    else
                    begin
                        frame_end_o <= 1'b1;
                        state_r     <= RX_IDLE;
                    end
                RX_HI:
                    if (mrxdv_i)
                    begin
                        byte_valid_o <= 1'b1;
                        state_r      <= RX_LO;
                    end
                    else
                    begin
                        // low nibble without its partner is dropped
                        frame_end_o  <= 1'b1;
                        odd_nibble_o <= 1'b1;
                        state_r      <= RX_IDLE;
                    end
                default:
                    state_r <= RX_IDLE;
            endcase
        end
    end

    // low nibble arrives first on the wire
    always_ff @(posedge mtx_clk_i)
    begin
        if (state_r == RX_LO && mrxdv_i)
            lo_nib_r <= mrxd_i;
        if (state_r == RX_HI && mrxdv_i)
            byte_data_o <= {mrxd_i, lo_nib_r};
    end

endmodule

// File: logic/fcs_checker.sv
`timescale 1ns/1ps
`include "phy_model_config.svh"

module fcs_checker
    import mii_pkg::*;
(
    input  logic       mtx_clk_i,
    input  logic       arst_n_i,
    input  logic       byte_valid_i,
    input  byte_t      byte_data_i,
    input  logic       frame_end_i,
    input  logic       odd_nibble_i,
    output logic       rx_byte_valid_o,
    output byte_t      rx_byte_o,
    output logic       rx_done_o,
    output frame_len_t rx_len_o,
    output logic       rx_fcs_ok_o,
    output frame_num_t rx_frame_num_o
);

    crc_t       crc_r;
    frame_len_t cnt_r;

    // one byte through the reflected crc, lsb first
    function automatic crc_t crc_byte(input crc_t crc_in, input byte_t data);
        crc_t c;
        c = crc_in ^ {{(32-`BYTE_W){1'b0}}, data};
        for (int i = 0; i < `BYTE_W; i++)
        begin
            if (c[0])
                c = (c >> 1) ^ `CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // ============================================================
    // running crc and byte count
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            crc_r <= `CRC_INIT;
            cnt_r <= '0;
        end
        else if (frame_end_i)
        begin
            // re-arm for the next frame
            crc_r <= `CRC_INIT;
            cnt_r <= '0;
        end
        else if (byte_valid_i)
        begin
            crc_r <= crc_byte(crc_r, byte_data_i);
            cnt_r <= cnt_r + 1'b1;
        end
    end

    // ============================================================
    // per-frame status, held until the next frame ends
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rx_byte_valid_o <= 1'b0;
            rx_done_o       <= 1'b0;
            rx_len_o        <= '0;
            rx_fcs_ok_o     <= 1'b0;
            rx_frame_num_o  <= '0;
        end
        else
        begin
            rx_byte_valid_o <= byte_valid_i;
            rx_done_o       <= frame_end_i;
            if (frame_end_i)
            begin
                rx_len_o    <= cnt_r;
                rx_fcs_ok_o <= (crc_r == `CRC_RESIDUE) && !odd_nibble_i;
                // frame number skips 0 once running
                if (rx_frame_num_o == 8'd255)
                    rx_frame_num_o <= 8'd1;
                else
                    rx_frame_num_o <= rx_frame_num_o + 1'b1;
            end
        end
    end

    always_ff @(posedge mtx_clk_i)
    begin
        rx_byte_o <= byte_data_i;
    end

endmodule

// File: logic/mdio_frame_decoder.sv
`timescale 1ns/1ps
`include "phy_model_config.svh"

module mdio_frame_decoder
    import mdio_pkg::*;
(
    input  logic       mtx_clk_i,
    input  logic       arst_n_i,
    input  logic       mdc_i,
    input  logic       md_i,
    output logic       md_oe_o,
    output mdio_addr_t reg_addr_o,
    output logic       wr_stb_o,
    output mdio_data_t wr_data_o,
    output logic       rd_load_o,
    output logic       rd_shift_o
);

    logic          mdc_meta_r;
    logic          mdc_sync_r;
    logic          mdc_prev_r;
    logic          mdc_rise;
    mdio_state_e   state_r;
    mdio_bit_cnt_t cnt_r;
    logic          op_rd_r;
    mdio_addr_t    reg_addr_r;
    mdio_data_t    wdata_r;

    // ============================================================
    // mdc synchronizer and rising edge detect
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mdc_meta_r <= 1'b0;
            mdc_sync_r <= 1'b0;
            mdc_prev_r <= 1'b0;
        end
        else
        begin
            mdc_meta_r <= mdc_i;
            mdc_sync_r <= mdc_meta_r;
            mdc_prev_r <= mdc_sync_r;
        end
    end

    assign mdc_rise = mdc_sync_r & ~mdc_prev_r;

    // ============================================================
    // frame state machine
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_r <= IDLE;
            cnt_r   <= '0;
            op_rd_r <= 1'b0;
        end
        else if (mdc_rise)
        begin
            case (state_r)
                IDLE:
                begin
                    cnt_r <= '0;
                    if (!md_i)
                        state_r <= START0;
                end
                START0:
                    state_r <= md_i ? START1 : IDLE;
                // first opcode bit picks the branch
                START1:
                    state_r <= md_i ? OP_RD : OP_WR;
                OP_RD:
                    if (!md_i)
                    begin
                        op_rd_r <= 1'b1;
                        state_r <= PHYADDR;
                    end
                    else
                        state_r <= IDLE;
                OP_WR:
                    if (md_i)
                    begin
                        op_rd_r <= 1'b0;
                        state_r <= PHYADDR;
                    end
                    else
                        state_r <= IDLE;
                // phy address bits are counted past and ignored
                PHYADDR:
                begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == 5'd4)
                    begin
                        cnt_r   <= '0;
                        state_r <= REGADDR;
                    end
                end
                REGADDR:
                begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == 5'd4)
                    begin
                        cnt_r   <= '0;
                        state_r <= TURN0;
                    end
                end
                TURN0:
                    state_r <= TURN1;
                TURN1:
                    state_r <= op_rd_r ? RDATA : WDATA;
                RDATA:
                begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == 5'd15)
                        state_r <= IDLE;
                end
                WDATA:
                begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == 5'd15)
                    begin
                        cnt_r   <= '0;
                        state_r <= WXFR;
                    end
                end
                WXFR:
                    state_r <= IDLE;
                default:
                    state_r <= IDLE;
            endcase
        end
    end

    // address and write data shift in msb first
    always_ff @(posedge mtx_clk_i)
    begin
        if (mdc_rise && state_r == REGADDR)
            reg_addr_r <= {reg_addr_r[`MDIO_ADDR_W-2:0], md_i};
        if (mdc_rise && state_r == WDATA)
            wdata_r <= {wdata_r[`MDIO_DATA_W-2:0], md_i};
    end

    // one-cycle strobes to the register file
    assign rd_load_o  = mdc_rise && state_r == TURN1 && op_rd_r;
    assign rd_shift_o = mdc_rise && state_r == RDATA;
    assign wr_stb_o   = mdc_rise && state_r == WXFR;

    assign reg_addr_o = reg_addr_r;
    assign wr_data_o  = wdata_r;
    assign md_oe_o    = (state_r == RDATA);

endmodule

// File: logic/phy_reg_file.sv
`timescale 1ns/1ps
`include "phy_model_config.svh"

module phy_reg_file
    import mdio_pkg::*;
(
    input  logic       mtx_clk_i,
    input  logic       arst_n_i,
    input  mdio_addr_t reg_addr_i,
    input  logic       wr_stb_i,
    input  mdio_data_t wr_data_i,
    input  logic       rd_load_i,
    input  logic       rd_shift_i,
    output logic       md_o
);

    mdio_data_t bmcr_r;
    mdio_data_t ctrl1000_r;
    mdio_data_t rd_sel;
    mdio_data_t shift_r;

    // ============================================================
    // writable registers
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            bmcr_r     <= `BMCR_RESET;
            ctrl1000_r <= `CTRL1000_RESET;
        end
        else if (wr_stb_i)
        begin
            // bmsr and unknown addresses drop the write
            case (reg_addr_i)
                `REG_BMCR:     bmcr_r     <= wr_data_i;
                `REG_CTRL1000: ctrl1000_r <= wr_data_i;
                default:       ;
            endcase
        end
    end

    // read mux
    always_comb
    begin
        case (reg_addr_i)
            `REG_BMCR:     rd_sel = bmcr_r;
            `REG_BMSR:     rd_sel = `BMSR_VALUE;
            `REG_CTRL1000: rd_sel = ctrl1000_r;
            default:       rd_sel = '0;
        endcase
    end

    // ============================================================
    // read shift register, msb goes out first
    // ============================================================
    always_ff @(posedge mtx_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            shift_r <= '0;
        else if (rd_load_i)
            shift_r <= rd_sel;
        else if (rd_shift_i)
            shift_r <= {shift_r[`MDIO_DATA_W-2:0], 1'b0};
    end

    assign md_o = shift_r[`MDIO_DATA_W-1];

endmodule

// File: logic/phy_model.sv
`timescale 1ns/1ps

module phy_model
    import mii_pkg::*;
    import mdio_pkg::*;
(
    input  logic       mtx_clk_i,
    input  logic       arst_n_i,
    // mii receive from the mac
    input  nibble_t    mrxd_i,
    input  logic       mrxdv_i,
    output logic       rx_byte_valid_o,
    output byte_t      rx_byte_o,
    output logic       rx_done_o,
    output frame_len_t rx_len_o,
    output logic       rx_fcs_ok_o,
    output frame_num_t rx_frame_num_o,
    // management interface
    input  logic       mdc_i,
    input  logic       md_i,
    output logic       md_o,
    output logic       md_oe_o
);

    logic       byte_valid;
    byte_t      byte_data;
    logic       frame_end;
    logic       odd_nibble;

    mdio_addr_t reg_addr;
    logic       wr_stb;
    mdio_data_t wr_data;
    logic       rd_load;
    logic       rd_shift;

    // ============================================================
    // receive path
    // ============================================================
    mii_rx_deframer u_deframer (
        .mtx_clk_i    (mtx_clk_i),
        .arst_n_i     (arst_n_i),
        .mrxd_i       (mrxd_i),
        .mrxdv_i      (mrxdv_i),
        .byte_valid_o (byte_valid),
        .byte_data_o  (byte_data),
        .frame_end_o  (frame_end),
        .odd_nibble_o (odd_nibble)
    );

    fcs_checker u_fcs (
        .mtx_clk_i       (mtx_clk_i),
        .arst_n_i        (arst_n_i),
        .byte_valid_i    (byte_valid),
        .byte_data_i     (byte_data),
        .frame_end_i     (frame_end),
        .odd_nibble_i    (odd_nibble),
        .rx_byte_valid_o (rx_byte_valid_o),
        .rx_byte_o       (rx_byte_o),
        .rx_done_o       (rx_done_o),
        .rx_len_o        (rx_len_o),
        .rx_fcs_ok_o     (rx_fcs_ok_o),
        .rx_frame_num_o  (rx_frame_num_o)
    );

    // ============================================================
    // management path
    // ============================================================
    mdio_frame_decoder u_mdio (
        .mtx_clk_i  (mtx_clk_i),
        .arst_n_i   (arst_n_i),
        .mdc_i      (mdc_i),
        .md_i       (md_i),
        .md_oe_o    (md_oe_o),
        .reg_addr_o (reg_addr),
        .wr_stb_o   (wr_stb),
        .wr_data_o  (wr_data),
        .rd_load_o  (rd_load),
        .rd_shift_o (rd_shift)
    );

    phy_reg_file u_regs (
        .mtx_clk_i  (mtx_clk_i),
        .arst_n_i   (arst_n_i),
        .reg_addr_i (reg_addr),
        .wr_stb_i   (wr_stb),
        .wr_data_i  (wr_data),
        .rd_load_i  (rd_load),
        .rd_shift_i (rd_shift),
        .md_o       (md_o)
    );

endmodule

// File: tb/tb_phy_model.sv
`timescale 1ns/1ps

module tb_phy_model;

    localparam int CLK_PERIOD = 100;

    logic        mtx_clk_i;
    logic        arst_n_i;
    logic [3:0]  mrxd_i;
    logic        mrxdv_i;
    logic        rx_byte_valid_o;
    logic [7:0]  rx_byte_o;
    logic        rx_done_o;
    logic [15:0] rx_len_o;
    logic        rx_fcs_ok_o;
    logic [7:0]  rx_frame_num_o;
    logic        mdc_i;
    logic        md_i;
    logic        md_o;
    logic        md_oe_o;

    // case table as read from the case file
    int          case_kind[$];
    int          case_a[$];
    int          case_b[$];
    int          case_c[$];

    // expected receive results, pushed before the frame is driven
    logic [7:0]  exp_bytes[$];
    logic [15:0] exp_len[$];
    logic        exp_ok[$];
    logic [7:0]  exp_num;
    int          frames_sent;
    int          frames_checked;
    int          bytes_seen;
    int          budget;
    logic        budget_ready;

    phy_model dut0 (.*);

    initial
    begin
        mtx_clk_i = 1'b0;
        forever
            #(CLK_PERIOD / 2) mtx_clk_i = ~mtx_clk_i;
    end

    // ============================================================
    // checking helpers
    // ============================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reflected crc-32, one data bit at a time
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            fb = c[0] ^ data[i];
            c  = c >> 1;
            if (fb)
                c = c ^ 32'hedb8_8320;
        end
        return c;
    endfunction

    // ============================================================
    // mii receive driver
    // ============================================================
    task automatic drive_nibble(input logic [3:0] nib);
        @(posedge mtx_clk_i);
        mrxdv_i <= 1'b1;
        mrxd_i  <= nib;
    endtask

    task automatic send_frame(input int len, input int mode);
        logic [7:0]  frame[$];
        logic [31:0] crc;
        int          idx;
        int          gap;
        crc = 32'hffff_ffff;
        for (int i = 0; i < len; i++)
        begin
            frame.push_back(8'($urandom));
            crc = crc_next(crc, frame[i]);
        end
        // fcs is the inverted register, low byte first
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            frame.push_back(crc[8*i +: 8]);
        if (mode == 1)
        begin
            idx = int'($urandom_range(len + 3, 0));
            frame[idx] = frame[idx] ^ 8'($urandom_range(255, 1));
        end
        foreach (frame[i])
            exp_bytes.push_back(frame[i]);
        exp_len.push_back(16'(len + 4));
        exp_ok.push_back(mode == 0);
        frames_sent++;
        gap = int'($urandom_range(8, 1));
        repeat (gap) @(posedge mtx_clk_i);
        for (int i = 0; i < 15; i++)
            drive_nibble(4'h5);
        drive_nibble(4'hd);
        foreach (frame[i])
        begin
            drive_nibble(frame[i][3:0]);
            drive_nibble(frame[i][7:4]);
        end
        // a lone trailing nibble makes the frame odd
        if (mode == 2)
            drive_nibble(4'($urandom));
        @(posedge mtx_clk_i);
        mrxdv_i <= 1'b0;
        mrxd_i  <= 4'h0;
        while (frames_checked != frames_sent)
            @(posedge mtx_clk_i);
    endtask

    // ============================================================
    // mdio master
    // ============================================================
    // one mdc period, 4 clocks low then 4 high, md_o sampled before the rise
    task automatic mdio_bit(input logic bit_val, input logic oe_exp, output logic md_seen);
        @(posedge mtx_clk_i);
        mdc_i <= 1'b0;
        md_i  <= bit_val;
        repeat (3) @(posedge mtx_clk_i);
        @(negedge mtx_clk_i);
        compare_value("md_oe_o", 32'(md_oe_o), 32'(oe_exp));
        md_seen = md_o;
        @(posedge mtx_clk_i);
        mdc_i <= 1'b1;
        repeat (3) @(posedge mtx_clk_i);
    endtask

    task automatic mdio_op(input logic is_read, input logic [4:0] addr,
                           input logic [15:0] wdata, input logic [15:0] rexp);
        logic [15:0] rdata;
        logic        seen;
        for (int i = 0; i < 32; i++)
            mdio_bit(1'b1, 1'b0, seen);
        // start 01, then opcode 10 for read or 01 for write
        mdio_bit(1'b0, 1'b0, seen);
        mdio_bit(1'b1, 1'b0, seen);
        mdio_bit(is_read, 1'b0, seen);
        mdio_bit(!is_read, 1'b0, seen);
        // phy address 1, any value is accepted
        for (int i = 4; i >= 0; i--)
            mdio_bit(i == 0, 1'b0, seen);
        for (int i = 4; i >= 0; i--)
            mdio_bit(addr[i], 1'b0, seen);
        // turnaround, line released on a read
        mdio_bit(1'b1, 1'b0, seen);
        mdio_bit(is_read, 1'b0, seen);
        for (int i = 15; i >= 0; i--)
        begin
            mdio_bit(is_read ? 1'b1 : wdata[i], is_read, seen);
            rdata[i] = seen;
        end
        // trailing idle bit, its rising edge also commits a write
        mdio_bit(1'b1, 1'b0, seen);
        if (is_read)
            compare_value("md_o read data", 32'(rdata), 32'(rexp));
    endtask

    // ============================================================
    // receive monitor
    // ============================================================
    initial
    begin
        logic [15:0] len_exp;
        logic        ok_exp;
        exp_num        = 8'd0;
        bytes_seen     = 0;
        frames_checked = 0;
        @(posedge arst_n_i);
        forever
        begin
            @(negedge mtx_clk_i);
            if (rx_byte_valid_o)
            begin
                if (exp_bytes.size() == 0)
                    abort_run("byte strobe seen with no frame in flight");
                else
                begin
                    compare_value("rx_byte_o", 32'(rx_byte_o), 32'(exp_bytes.pop_front()));
                    bytes_seen++;
                end
            end
            if (rx_done_o)
            begin
                if (exp_len.size() == 0)
                    abort_run("rx_done_o seen with no frame in flight");
                else
                begin
                    len_exp = exp_len.pop_front();
                    ok_exp  = exp_ok.pop_front();
                    // frame numbers run 1 to 255, then back to 1
                    exp_num = (exp_num == 8'd255) ? 8'd1 : exp_num + 8'd1;
                    compare_value("rx_len_o", 32'(rx_len_o), 32'(len_exp));
                    compare_value("received byte count", 32'(bytes_seen), 32'(len_exp));
                    compare_value("rx_fcs_ok_o", 32'(rx_fcs_ok_o), 32'(ok_exp));
                    compare_value("rx_frame_num_o", 32'(rx_frame_num_o), 32'(exp_num));
                    bytes_seen = 0;
                    frames_checked++;
                end
            end
        end
    end

    // watchdog, armed once the case file has been sized
    initial
    begin
        wait (budget_ready);
        repeat (budget) @(posedge mtx_clk_i);
        abort_run($sformatf("run timed out after %0d clock cycles", budget));
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial
    begin
        int    fd;
        string line;
        int    kind;
        int    a;
        int    b;
        int    c;
        int    n;
        void'($urandom(32'h22c0_cd22));
        arst_n_i     = 1'b0;
        mrxd_i       = 4'h0;
        mrxdv_i      = 1'b0;
        mdc_i        = 1'b0;
        md_i         = 1'b1;
        frames_sent  = 0;
        budget       = 0;
        budget_ready = 1'b0;

        fd = $fopen("tb/phy_model_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open the case file tb/phy_model_cases.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %h %h %h", kind, a, b, c);
                if (n == 4)
                begin
                    case_kind.push_back(kind);
                    case_a.push_back(a);
                    case_b.push_back(b);
                    case_c.push_back(c);
                end
            end
        end
        $fclose(fd);

        // frame: gap, preamble, two nibbles per byte, odd nibble, done latency
        foreach (case_kind[i])
        begin
            if (case_kind[i] == 1)
                budget += case_a[i] * (9 + 16 + 2 * (case_b[i] + 4) + 1 + 6);
            else
                budget += 66 * 8;
        end
        budget       = 2 * budget;
        budget_ready = 1'b1;

        repeat (3) @(posedge mtx_clk_i);
        arst_n_i <= 1'b1;
        @(negedge mtx_clk_i);
        compare_value("rx_byte_valid_o", 32'(rx_byte_valid_o), 32'h0);
        compare_value("rx_done_o", 32'(rx_done_o), 32'h0);
        compare_value("md_oe_o", 32'(md_oe_o), 32'h0);
        compare_value("rx_frame_num_o", 32'(rx_frame_num_o), 32'h0);

        foreach (case_kind[i])
        begin
            case (case_kind[i])
                1:
                    repeat (case_a[i]) send_frame(case_b[i], case_c[i]);
                2:
                    mdio_op(1'b1, 5'(case_a[i]), 16'h0000, 16'(case_c[i]));
                3:
                    mdio_op(1'b0, 5'(case_a[i]), 16'(case_b[i]), 16'h0000);
                default:
                    abort_run($sformatf("unknown case kind %0d in the case file", case_kind[i]));
            endcase
        end

        repeat (4) @(posedge mtx_clk_i);
        if (exp_bytes.size() != 0 || exp_len.size() != 0)
            abort_run("receive results still outstanding at the end of the run");
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: tb/phy_model_cases.txt
# kind 1 receive frames: count, payload length, mode (0 good, 1 corrupt byte, 2 odd nibble)
# kind 2 mdio read: address, unused, expected data; kind 3 mdio write: address, data, unused
2 00 0000 0000
2 09 0000 ffff
2 01 0000 fe04
2 05 0000 0000
1 1 40 0
1 1 0 0
1 1 2e 1
1 1 10 2
1 2 8 0
3 00 1234 0000
2 00 0000 1234
3 09 0a5c 0000
2 09 0000 0a5c
3 01 0000 0000
2 01 0000 fe04
3 05 beef 0000
2 05 0000 0000
1 100 4 0
1 3 1 1
1 2 7 2
1 1 5dc 0
2 00 0000 1234
2 09 0000 0a5c

// File: phy_model.f
+incdir+logic
logic/mii_pkg.sv
logic/mdio_pkg.sv
logic/mii_rx_deframer.sv
logic/fcs_checker.sv
logic/mdio_frame_decoder.sv
logic/phy_reg_file.sv
logic/phy_model.sv
tb/tb_phy_model.sv

// File: run.sh
#!/bin/sh
# build and run the phy model testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_phy_model \
    -f phy_model.f \
    -o tb_phy_model

sim_out=$(./obj_dir/tb_phy_model 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"
then
    exit 0
fi
exit 1
